// File: all.f
hdl/mgmt_pkg.sv
hdl/mdio_pkg.sv
hdl/mgmt_regs.sv
hdl/mdio_master.sv
hdl/fan_tach.sv
hdl/mgmt_subsystem.sv
sim/mdio_phy_model.sv
sim/tb_mgmt_subsystem.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_mgmt_subsystem
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= All checks passed

.PHONY: sim clean

# Build, run, and pass only if the pass line appears
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
		echo "$$out"; \
		echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: sim/tb_mgmt_subsystem.sv
`timescale 1ns/1ps

module tb_mgmt_subsystem;

	localparam int IDLE_TIMEOUT = 2000;
	localparam int RPM_RETRIES  = 4;

	logic                           sys_clk;
	logic                           rst;
	logic                           rd_en;
	logic [mgmt_pkg::ADDR_BITS-1:0] rd_addr;
	logic                           wr_en;
	logic [mgmt_pkg::ADDR_BITS-1:0] wr_addr;
	logic [mgmt_pkg::DATA_BITS-1:0] wr_data;
	wire                            rd_valid;
	wire [mgmt_pkg::DATA_BITS-1:0]  rd_data;
	wire [1:0]                      fan_tach;
	wire                            mdc;
	wire                            mdio_out;
	wire                            mdio_oe;
	wire                            mdio_in;
	wire [31:0]                     phy_frames;

	integer      seed;
	int          checks;
	int          errors;
	int          test_mark;

	// Reference copy of the request registers and the PHY
	logic [7:0]  m_phy_addr;
	logic [7:0]  m_reg_addr;
	logic [15:0] m_wdata;
	logic [15:0] m_rdata;
	logic [15:0] m_mem [0:1023];
	bit          m_written [0:1023];

	// Tach stimulus, held low until a test starts it
	bit          tach_run;
	logic [1:0]  tach_lvl;
	int          tach_half [0:1];
	int          tach_cnt [0:1];

	assign fan_tach = tach_run ? tach_lvl : 2'b00;

	initial sys_clk = 1'b0;
	always #2 sys_clk = ~sys_clk;

	mgmt_subsystem u_mgmt_subsystem(
		.sys_clk(sys_clk),
		.rst(rst),
		.rd_en(rd_en),
		.rd_addr(rd_addr),
		.rd_valid(rd_valid),
		.rd_data(rd_data),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.fan_tach(fan_tach),
		.mdc(mdc),
		.mdio_out(mdio_out),
		.mdio_oe(mdio_oe),
		.mdio_in(mdio_in)
	);

	mdio_phy_model u_phy(
		.mdc(mdc),
		.mdio_out(mdio_out),
		.mdio_oe(mdio_oe),
		.mdio_in(mdio_in),
		.frame_count(phy_frames)
	);

	// Each fan toggles every tach_half cycles
	always @(negedge sys_clk) begin
		for (int i = 0; i < 2; i++) begin
			if (!tach_run) begin
				tach_cnt[i] = 0;
				tach_lvl[i] <= 1'b0;
			end else if (tach_cnt[i] >= tach_half[i] - 1) begin
				tach_cnt[i] = 0;
				tach_lvl[i] <= ~tach_lvl[i];
			end else begin
				tach_cnt[i] = tach_cnt[i] + 1;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Checking and reference model helpers

	task automatic check(input string name, input logic [31:0] got,
		input logic [31:0] exp, input int tol);
		int diff;
		diff = (got > exp) ? int'(got - exp) : int'(exp - got);
		checks++;
		if ($isunknown(got) || diff > tol) begin
			errors++;
			$display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
		end
	endtask

	function automatic bit is_mapped(input logic [15:0] addr);
		return (addr <= 16'h0003) || (addr >= 16'h0010 && addr <= 16'h0017);
	endfunction

	function automatic logic [15:0] random_unmapped();
		logic [15:0] a;
		a = 16'($random(seed));
		for (int n = 0; n < 64 && is_mapped(a); n++)
			a = 16'($random(seed));
		if (is_mapped(a))
			a = 16'h8000;
		return a;
	endfunction

	// PHY registers default to 0xA500 plus phy*32 plus reg
	function automatic logic [15:0] phy_reg_expect(input logic [9:0] idx);
		return m_written[idx] ? m_mem[idx] : 16'hA500 + 16'(idx);
	endfunction

	task automatic report_test(input string name);
		$display("Test %s finished, %0d mismatches", name, errors - test_mark);
		test_mark = errors;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Register bus access

	task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
		@(negedge sys_clk);
		wr_en   = 1'b1;
		wr_addr = addr;
		wr_data = data;
		@(negedge sys_clk);
		wr_en   = 1'b0;
	endtask

	// Data returns one cycle after the strobe
	task automatic bus_read(input logic [15:0] addr, output logic [7:0] data);
		@(negedge sys_clk);
		rd_en   = 1'b1;
		rd_addr = addr;
		@(negedge sys_clk);
		rd_en   = 1'b0;
		check("rd_valid", 32'(rd_valid), 32'd1, 0);
		data = rd_data;
	endtask

	task automatic expect_read(input logic [15:0] addr, input logic [7:0] exp);
		logic [7:0] data;
		bus_read(addr, data);
		check($sformatf("rd_data[0x%04h]", addr), 32'(data), 32'(exp), 0);
	endtask

	task automatic expect_request();
		expect_read(mgmt_pkg::REG_MDIO_PHY_ADDR, m_phy_addr);
		expect_read(mgmt_pkg::REG_MDIO_REG_ADDR, m_reg_addr);
		expect_read(mgmt_pkg::REG_MDIO_WDATA_LO, m_wdata[7:0]);
		expect_read(mgmt_pkg::REG_MDIO_WDATA_HI, m_wdata[15:8]);
	endtask

	task automatic check_rdata();
		expect_read(mgmt_pkg::REG_MDIO_RDATA_LO, m_rdata[7:0]);
		expect_read(mgmt_pkg::REG_MDIO_RDATA_HI, m_rdata[15:8]);
	endtask

	task automatic set_request(input logic [7:0] phy, input logic [7:0] regn,
		input logic [15:0] wdata);
		bus_write(mgmt_pkg::REG_MDIO_PHY_ADDR, phy);
		bus_write(mgmt_pkg::REG_MDIO_REG_ADDR, regn);
		bus_write(mgmt_pkg::REG_MDIO_WDATA_LO, wdata[7:0]);
		bus_write(mgmt_pkg::REG_MDIO_WDATA_HI, wdata[15:8]);
		m_phy_addr = phy;
		m_reg_addr = regn;
		m_wdata    = wdata;
	endtask

	// Poll status until busy clears
	task automatic wait_idle();
		logic [7:0] status;
		int         polls;
		polls = 0;
		bus_read(mgmt_pkg::REG_MDIO_STATUS, status);
		while (status[0] && polls < IDLE_TIMEOUT) begin
			bus_read(mgmt_pkg::REG_MDIO_STATUS, status);
			polls++;
		end
		if (status[0]) begin
			errors++;
			$display("MDIO busy did not clear within %0d status polls", IDLE_TIMEOUT);
		end
	endtask

	task automatic run_mdio(input logic [7:0] cmd);
		logic [9:0] idx;
		idx = {m_phy_addr[4:0], m_reg_addr[4:0]};
		bus_write(mgmt_pkg::REG_MDIO_CMD, cmd);
		wait_idle();
		if (cmd == mgmt_pkg::CMD_WRITE) begin
			m_mem[idx]     = m_wdata;
			m_written[idx] = 1'b1;
		end else begin
			m_rdata = phy_reg_expect(idx);
		end
	endtask

	// Rereads the high byte so a window update between bytes is caught
	task automatic read_rpm(input logic [15:0] lo_addr, output logic [15:0] rpm);
		logic [7:0] hi_a;
		logic [7:0] lo;
		logic [7:0] hi_b;
		int         tries;
		tries = 0;
		do begin
			bus_read(lo_addr + 16'd1, hi_a);
			bus_read(lo_addr, lo);
			bus_read(lo_addr + 16'd1, hi_b);
			tries++;
		end while (hi_a != hi_b && tries < RPM_RETRIES);
		if (hi_a != hi_b) begin
			errors++;
			$display("RPM high byte at 0x%04h kept changing between reads", lo_addr);
		end
		rpm = {hi_b, lo};
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence

	initial begin : stimulus
		logic [15:0] zero_regs [0:7];
		logic [15:0] first;
		logic [15:0] second;
		logic [15:0] rpm;
		logic [9:0]  idx;
		int          frames_before;
		int          exp_rpm;

		seed       = 32'hf9978535;
		rst        = 1'b1;
		rd_en      = 1'b0;
		rd_addr    = '0;
		wr_en      = 1'b0;
		wr_addr    = '0;
		wr_data    = '0;
		checks     = 0;
		errors     = 0;
		test_mark  = 0;
		m_phy_addr = '0;
		m_reg_addr = '0;
		m_wdata    = '0;
		m_rdata    = '0;
		repeat (2) @(negedge sys_clk);
		rst = 1'b0;

		// Reset values
		zero_regs = '{mgmt_pkg::REG_MDIO_STATUS, mgmt_pkg::REG_FAN0_RPM_LO,
			mgmt_pkg::REG_FAN0_RPM_HI, mgmt_pkg::REG_FAN1_RPM_LO,
			mgmt_pkg::REG_FAN1_RPM_HI, mgmt_pkg::REG_MDIO_RDATA_LO,
			mgmt_pkg::REG_MDIO_RDATA_HI, random_unmapped()};
		foreach (zero_regs[i])
			expect_read(zero_regs[i], 8'h00);
		report_test("reset values");

		// Request registers, then an unmapped write that must not land
		set_request(8'($random(seed)), 8'($random(seed)), 16'($random(seed)));
		expect_request();
		bus_write(random_unmapped(), 8'($random(seed)));
		expect_request();
		report_test("request readback");

		set_request(8'($random(seed)), 8'($random(seed)), 16'($random(seed)));
		run_mdio(mgmt_pkg::CMD_WRITE);
		run_mdio(mgmt_pkg::CMD_READ);
		check_rdata();
		report_test("mdio write then read");

		// Never written PHY register
		idx = 10'($random(seed));
		for (int n = 0; n < 1024 && m_written[idx]; n++)
			idx = idx + 10'd1;
		set_request({3'b000, idx[9:5]}, {3'b000, idx[4:0]}, 16'($random(seed)));
		run_mdio(mgmt_pkg::CMD_READ);
		check_rdata();
		report_test("mdio default read");

		// Second command while the first frame is still on the wire
		first  = 16'($random(seed));
		second = ~first;
		set_request(8'($random(seed)), 8'($random(seed)), first);
		idx = {m_phy_addr[4:0], m_reg_addr[4:0]};
		frames_before = int'(phy_frames);
		bus_write(mgmt_pkg::REG_MDIO_CMD, mgmt_pkg::CMD_WRITE);
		bus_write(mgmt_pkg::REG_MDIO_WDATA_LO, second[7:0]);
		bus_write(mgmt_pkg::REG_MDIO_WDATA_HI, second[15:8]);
		m_wdata = second;
		bus_write(mgmt_pkg::REG_MDIO_CMD, mgmt_pkg::CMD_WRITE);
		wait_idle();
		m_mem[idx]     = first;
		m_written[idx] = 1'b1;
		check("phy_frames", phy_frames, 32'(frames_before + 1), 0);
		run_mdio(mgmt_pkg::CMD_READ);
		check_rdata();
		report_test("command while busy");

		// Full periods of 20 to 78 cycles
		tach_half[0] = 10 + int'({$random(seed)} % 32'd30);
		tach_half[1] = 10 + int'({$random(seed)} % 32'd30);
		tach_run = 1'b1;
		repeat (2 * mgmt_pkg::TACH_WINDOW_CYCLES + 20) @(negedge sys_clk);
		read_rpm(mgmt_pkg::REG_FAN0_RPM_LO, rpm);
		exp_rpm = mgmt_pkg::TACH_WINDOW_CYCLES * mgmt_pkg::TACH_RPM_SCALE /
			(2 * tach_half[0]);
		check("fan0_rpm", 32'(rpm), 32'(exp_rpm), mgmt_pkg::TACH_RPM_SCALE);
		read_rpm(mgmt_pkg::REG_FAN1_RPM_LO, rpm);
		exp_rpm = mgmt_pkg::TACH_WINDOW_CYCLES * mgmt_pkg::TACH_RPM_SCALE /
			(2 * tach_half[1]);
		check("fan1_rpm", 32'(rpm), 32'(exp_rpm), mgmt_pkg::TACH_RPM_SCALE);
		tach_run = 1'b0;
		report_test("fan tach rpm");

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// File: sim/mdio_phy_model.sv
`timescale 1ns/1ps

module mdio_phy_model(
	input wire         mdc,
	input wire         mdio_out,
	input wire         mdio_oe,
	output wire        mdio_in,
	output wire [31:0] frame_count
);

	// Register file indexed by {phy, reg}
	logic [15:0]           regs [0:1023];
	bit                    written [0:1023];

	mdio_pkg::mdio_frame_t frame;
	int                    ones;
	int                    bit_idx;
	int                    frames;
	bit                    in_frame;
	bit                    drive_low;
	logic [15:0]           rd_word;
	logic [9:0]            idx;

	// Shared data line, pulled high unless the master or the PHY drives it low
	assign mdio_in     = ((mdio_oe === 1'b1) ? mdio_out : 1'b1) & ~drive_low;
	assign frame_count = 32'(frames);

	// Unwritten registers follow the address based fill rule
	function automatic logic [15:0] reg_value(input logic [9:0] a);
		return written[a] ? regs[a] : 16'hA500 + 16'(a);
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Frame capture on rising MDC

	always @(posedge mdc) begin
		if (!in_frame) begin
			// Hunt for a full preamble then the first start bit
			if (mdio_in) begin
				ones = ones + 1;
			end else begin
				if (ones >= mdio_pkg::MDIO_PREAMBLE_BITS) begin
					in_frame  = 1'b1;
					bit_idx   = 1;
					frame.raw = '0;
				end
				ones = 0;
			end
		end else begin
			frame.raw[31 - bit_idx] = mdio_in;
			bit_idx = bit_idx + 1;
			// Address known so read data is looked up ahead of turnaround
			if (bit_idx == 14) begin
				idx     = {frame.f.phy, frame.f.reg_addr};
				rd_word = reg_value(idx);
			end
			if (bit_idx == 32) begin
				frames = frames + 1;
				if (frame.f.op == mdio_pkg::OP_WRITE) begin
					regs[idx]    = frame.f.data;
					written[idx] = 1'b1;
				end
				in_frame = 1'b0;
				ones     = 0;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Read data driven after falling MDC

	always @(negedge mdc) begin
		drive_low = 1'b0;
		if (in_frame && frame.f.op == mdio_pkg::OP_READ) begin
			// Second turnaround bit is a driven zero
			if (bit_idx == 15)
				drive_low = 1'b1;
			else if (bit_idx >= 16)
				drive_low = !rd_word[31 - bit_idx];
		end
	end

endmodule

// File: hdl/mgmt_subsystem.sv
`timescale 1ns/1ps

module mgmt_subsystem(
	input wire                            sys_clk,
	input wire                            rst,

	// Host register bus
	input wire                            rd_en,
	input wire [mgmt_pkg::ADDR_BITS-1:0]  rd_addr,
	output wire                           rd_valid,
	output wire [mgmt_pkg::DATA_BITS-1:0] rd_data,
	input wire                            wr_en,
	input wire [mgmt_pkg::ADDR_BITS-1:0]  wr_addr,
	input wire [mgmt_pkg::DATA_BITS-1:0]  wr_data,

	// Fan tachometer inputs
	input wire [1:0]                      fan_tach,

	// PHY management pins
	output wire                           mdc,
	output wire                           mdio_out,
	output wire                           mdio_oe,
	input wire                            mdio_in
);

	//////////////////////////////////////////////////////////////////////
	// Internal wiring

	wire [mgmt_pkg::RPM_BITS-1:0]         fan0_rpm;
	wire [mgmt_pkg::RPM_BITS-1:0]         fan1_rpm;

	wire                                  mdio_start;
	wire                                  mdio_read;
	wire [mdio_pkg::PHY_ADDR_BITS-1:0]    mdio_phy;
	wire [mdio_pkg::REG_ADDR_BITS-1:0]    mdio_reg;
	wire [mdio_pkg::MDIO_DATA_BITS-1:0]   mdio_wdata;
	wire                                  mdio_busy;
	wire                                  mdio_done;
	wire [mdio_pkg::MDIO_DATA_BITS-1:0]   mdio_rdata;

	//////////////////////////////////////////////////////////////////////
	// Register block

	mgmt_regs u_regs(
		.sys_clk(sys_clk),
		.rst(rst),
		.rd_en(rd_en),
		.rd_addr(rd_addr),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.rd_valid(rd_valid),
		.rd_data(rd_data),
		.fan0_rpm(fan0_rpm),
		.fan1_rpm(fan1_rpm),
		.mdio_busy(mdio_busy),
		.mdio_done(mdio_done),
		.mdio_rdata(mdio_rdata),
		.mdio_start(mdio_start),
		.mdio_read(mdio_read),
		.mdio_phy(mdio_phy),
		.mdio_reg(mdio_reg),
		.mdio_wdata(mdio_wdata)
	);

	//////////////////////////////////////////////////////////////////////
	// MDIO master

	mdio_master u_mdio(
		.sys_clk(sys_clk),
		.rst(rst),
		.mdio_start(mdio_start),
		.mdio_read(mdio_read),
		.mdio_phy(mdio_phy),
		.mdio_reg(mdio_reg),
		.mdio_wdata(mdio_wdata),
		.mdio_busy(mdio_busy),
		.mdio_done(mdio_done),
		.mdio_rdata(mdio_rdata),
		.mdc(mdc),
		.mdio_out(mdio_out),
		.mdio_oe(mdio_oe),
		.mdio_in(mdio_in)
	);

	//////////////////////////////////////////////////////////////////////
	// Tachometers, one per fan

	fan_tach u_tach0(
		.sys_clk(sys_clk),
		.rst(rst),
		.tach(fan_tach[0]),
		.rpm(fan0_rpm)
	);

	fan_tach u_tach1(
		.sys_clk(sys_clk),
		.rst(rst),
		.tach(fan_tach[1]),
		.rpm(fan1_rpm)
	);

endmodule

// File: hdl/fan_tach.sv
`timescale 1ns/1ps

module fan_tach(
	input wire                           sys_clk,
	input wire                           rst,
	input wire                           tach,
	output logic [mgmt_pkg::RPM_BITS-1:0] rpm
);

	logic                                  tach_meta;
	logic                                  tach_sync;
	logic                                  tach_prev;
	logic                                  tach_rise;
	logic                                  window_end;
	logic [mgmt_pkg::TACH_WINDOW_BITS-1:0] window_cnt;
	logic [mgmt_pkg::TACH_WINDOW_BITS-1:0] edge_cnt;
	logic [mgmt_pkg::TACH_WINDOW_BITS-1:0] edge_total;

	//////////////////////////////////////////////////////////////////////
	// Input synchronizer and edge detect

	always_ff @(posedge sys_clk) begin
		if (rst) begin
			tach_meta <= 1'b0;
			tach_sync <= 1'b0;
			tach_prev <= 1'b0;
		end else begin
			tach_meta <= tach;
			tach_sync <= tach_meta;
			tach_prev <= tach_sync;
		end
	end

	assign tach_rise  = tach_sync & ~tach_prev;
	assign window_end = (window_cnt == mgmt_pkg::TACH_WINDOW_LAST);

	// Includes an edge landing on the last cycle of the window
	assign edge_total = edge_cnt + mgmt_pkg::TACH_WINDOW_BITS'(tach_rise);

	//////////////////////////////////////////////////////////////////////
	// Window counter and scaled result

	always_ff @(posedge sys_clk) begin
		if (rst) begin
			window_cnt <= '0;
			edge_cnt   <= '0;
			rpm        <= '0;
		end else if (window_end) begin
			window_cnt <= '0;
			edge_cnt   <= '0;
			rpm        <= mgmt_pkg::RPM_BITS'(edge_total * mgmt_pkg::TACH_RPM_SCALE);
		end else begin
			window_cnt <= window_cnt + 1'b1;
			edge_cnt   <= edge_total;
		end
	end

	// Holds across windows, not only at the update
	a_rpm_scaled: assert property (@(posedge sys_clk) disable iff (rst)
		(rpm % mgmt_pkg::TACH_RPM_SCALE) == 0);

endmodule

// File: hdl/mdio_master.sv
`timescale 1ns/1ps

module mdio_master(
	input wire                                  sys_clk,
	input wire                                  rst,

	// Request from the register block
	input wire                                  mdio_start,
	input wire                                  mdio_read,
	input wire [mdio_pkg::PHY_ADDR_BITS-1:0]    mdio_phy,
	input wire [mdio_pkg::REG_ADDR_BITS-1:0]    mdio_reg,
	input wire [mdio_pkg::MDIO_DATA_BITS-1:0]   mdio_wdata,
	output logic                                mdio_busy,
	output logic                                mdio_done,
	output logic [mdio_pkg::MDIO_DATA_BITS-1:0] mdio_rdata,

	// MDIO pins, split data pin
	output logic                                mdc,
	output logic                                mdio_out,
	output logic                                mdio_oe,
	input wire                                  mdio_in
);

	mdio_pkg::mdio_frame_t                    frame_init;
	mdio_pkg::mdio_frame_t                    frame_sr;
	logic [mdio_pkg::MDIO_DIV_BITS-1:0]       div_cnt;
	logic [mdio_pkg::MDIO_BIT_CNT_BITS-1:0]   bit_cnt;
	logic [mdio_pkg::MDIO_BIT_CNT_BITS-1:0]   next_bit;
	logic                                     is_read;
	logic                                     half_tick;

	//////////////////////////////////////////////////////////////////////
	// Frame assembly through the field view

	always_comb begin
		frame_init.f.start    = mdio_pkg::MDIO_START;
		frame_init.f.op       = mdio_read ? mdio_pkg::OP_READ : mdio_pkg::OP_WRITE;
		frame_init.f.phy      = mdio_phy;
		frame_init.f.reg_addr = mdio_reg;
		frame_init.f.ta       = mdio_read ? mdio_pkg::MDIO_TA_READ : mdio_pkg::MDIO_TA_WRITE;
		// PHY fills the data bits on reads
		frame_init.f.data     = mdio_read ? '0 : mdio_wdata;
	end

	// One MDC half period elapsed
	assign half_tick = (div_cnt == mdio_pkg::MDIO_DIV_LAST);
	assign next_bit  = bit_cnt + 1'b1;

	//////////////////////////////////////////////////////////////////////
	// Clock divider and bit sequencing

	always_ff @(posedge sys_clk) begin
		if (rst) begin
			mdio_busy <= 1'b0;
			mdio_done <= 1'b0;
			mdc       <= 1'b0;
			mdio_out  <= 1'b0;
			mdio_oe   <= 1'b0;
			div_cnt   <= '0;
			bit_cnt   <= '0;
			is_read   <= 1'b0;
		end else begin
			mdio_done <= 1'b0;

			if (!mdio_busy) begin
				// Idle, MDC parked low
				if (mdio_start) begin
					mdio_busy <= 1'b1;
					is_read   <= mdio_read;
					div_cnt   <= '0;
					bit_cnt   <= '0;
					mdc       <= 1'b0;
					// First preamble bit goes out right away
					mdio_oe   <= 1'b1;
					mdio_out  <= 1'b1;
				end
			end else if (half_tick) begin
				div_cnt <= '0;
				mdc     <= !mdc;

				// Falling edge, move to the next bit
				if (mdc) begin
					if (bit_cnt == mdio_pkg::MDIO_LAST_BIT) begin
						mdio_busy <= 1'b0;
						mdio_done <= 1'b1;
						mdio_oe   <= 1'b0;
						mdio_out  <= 1'b0;
					end else begin
						bit_cnt <= next_bit;
						if (next_bit >= mdio_pkg::MDIO_FRAME_FIRST)
							mdio_out <= frame_sr.raw[mdio_pkg::MDIO_FRAME_BITS-1];
						else
							mdio_out <= 1'b1;

						// Release the line for turnaround and read data
						if (is_read && (next_bit >= mdio_pkg::MDIO_TA_FIRST))
							mdio_oe <= 1'b0;
					end
				end
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Raw shift out and read capture

	always_ff @(posedge sys_clk) begin
		if (mdio_start && !mdio_busy) begin
			frame_sr <= frame_init;
		end else if (mdio_busy && half_tick) begin
			// Shift as each frame bit is presented
			if (mdc && (next_bit >= mdio_pkg::MDIO_FRAME_FIRST))
				frame_sr.raw <= {frame_sr.raw[mdio_pkg::MDIO_FRAME_BITS-2:0], 1'b0};

			// Rising edge, sample PHY data MSB first
			if (!mdc && is_read && (bit_cnt >= mdio_pkg::MDIO_DATA_FIRST))
				mdio_rdata <= {mdio_rdata[mdio_pkg::MDIO_DATA_BITS-2:0], mdio_in};
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Checks

	// Data pin never driven outside a transaction
	a_oe_idle: assert property (@(posedge sys_clk) disable iff (rst)
		!mdio_busy |-> !mdio_oe);

endmodule

// File: hdl/mgmt_regs.sv
`timescale 1ns/1ps

module mgmt_regs(
	input wire                                  sys_clk,
	input wire                                  rst,

	// Host register bus
	input wire                                  rd_en,
	input wire [mgmt_pkg::ADDR_BITS-1:0]        rd_addr,
	input wire                                  wr_en,
	input wire [mgmt_pkg::ADDR_BITS-1:0]        wr_addr,
	input wire [mgmt_pkg::DATA_BITS-1:0]        wr_data,
	output logic                                rd_valid,
	output logic [mgmt_pkg::DATA_BITS-1:0]      rd_data,

	// Tachometer results
	input wire [mgmt_pkg::RPM_BITS-1:0]         fan0_rpm,
	input wire [mgmt_pkg::RPM_BITS-1:0]         fan1_rpm,

	// MDIO master
	input wire                                  mdio_busy,
	input wire                                  mdio_done,
	input wire [mdio_pkg::MDIO_DATA_BITS-1:0]   mdio_rdata,
	output logic                                mdio_start,
	output logic                                mdio_read,
	output logic [mdio_pkg::PHY_ADDR_BITS-1:0]  mdio_phy,
	output logic [mdio_pkg::REG_ADDR_BITS-1:0]  mdio_reg,
	output logic [mdio_pkg::MDIO_DATA_BITS-1:0] mdio_wdata
);

	//////////////////////////////////////////////////////////////////////
	// Pipeline register on write data

	logic                                wr_en_ff;
	logic [mgmt_pkg::ADDR_BITS-1:0]      wr_addr_ff;
	logic [mgmt_pkg::DATA_BITS-1:0]      wr_data_ff;

	// Full bytes kept so the host reads back what it wrote
	logic [mgmt_pkg::DATA_BITS-1:0]      phy_addr_r;
	logic [mgmt_pkg::DATA_BITS-1:0]      reg_addr_r;
	logic [mdio_pkg::MDIO_DATA_BITS-1:0] rdata_r;

	logic                                busy_flag;
	logic                                cmd_valid;
	logic                                cmd_ok;
	logic [mgmt_pkg::DATA_BITS-1:0]      rd_mux;

	always_ff @(posedge sys_clk) begin
		if (rst)
			wr_en_ff <= 1'b0;
		else
			wr_en_ff <= wr_en;
	end

	// Address and data only matter while wr_en_ff is set
	always_ff @(posedge sys_clk) begin
		wr_addr_ff <= wr_addr;
		wr_data_ff <= wr_data;
	end

	//////////////////////////////////////////////////////////////////////
	// Command acceptance

	// Start strobe counts as busy, the master raises busy one cycle later
	assign busy_flag = mdio_busy | mdio_start;

	assign cmd_valid = (wr_data_ff == mgmt_pkg::CMD_READ) ||
		(wr_data_ff == mgmt_pkg::CMD_WRITE);

	// Commands arriving while busy are dropped here
	assign cmd_ok = wr_en_ff && (wr_addr_ff == mgmt_pkg::REG_MDIO_CMD) &&
		cmd_valid && !busy_flag;

	assign mdio_phy = phy_addr_r[mdio_pkg::PHY_ADDR_BITS-1:0];
	assign mdio_reg = reg_addr_r[mdio_pkg::REG_ADDR_BITS-1:0];

	//////////////////////////////////////////////////////////////////////
	// Request and result registers

	always_ff @(posedge sys_clk) begin
		if (rst) begin
			mdio_start <= 1'b0;
			mdio_read  <= 1'b0;
			phy_addr_r <= '0;
			reg_addr_r <= '0;
			mdio_wdata <= '0;
			rdata_r    <= '0;
		end else begin
			mdio_start <= cmd_ok;

			// Op is held for the whole transaction
			if (cmd_ok)
				mdio_read <= (wr_data_ff == mgmt_pkg::CMD_READ);

			// Read completion, mdio_read still holds the finished op
			if (mdio_done && mdio_read)
				rdata_r <= mdio_rdata;

			if (wr_en_ff) begin
				case (wr_addr_ff)
					mgmt_pkg::REG_MDIO_PHY_ADDR: phy_addr_r <= wr_data_ff;
					mgmt_pkg::REG_MDIO_REG_ADDR: reg_addr_r <= wr_data_ff;
					mgmt_pkg::REG_MDIO_WDATA_LO: mdio_wdata[7:0] <= wr_data_ff;
					mgmt_pkg::REG_MDIO_WDATA_HI: mdio_wdata[15:8] <= wr_data_ff;
					// Unmapped, ignored
					default: ;
				endcase
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Read path, fixed one cycle return

	always_comb begin
		rd_mux = '0;
		case (rd_addr)
			mgmt_pkg::REG_FAN0_RPM_LO:   rd_mux = fan0_rpm[7:0];
			mgmt_pkg::REG_FAN0_RPM_HI:   rd_mux = fan0_rpm[15:8];
			mgmt_pkg::REG_FAN1_RPM_LO:   rd_mux = fan1_rpm[7:0];
			mgmt_pkg::REG_FAN1_RPM_HI:   rd_mux = fan1_rpm[15:8];
			mgmt_pkg::REG_MDIO_STATUS:   rd_mux = {7'b0, busy_flag};
			mgmt_pkg::REG_MDIO_PHY_ADDR: rd_mux = phy_addr_r;
			mgmt_pkg::REG_MDIO_REG_ADDR: rd_mux = reg_addr_r;
			mgmt_pkg::REG_MDIO_WDATA_LO: rd_mux = mdio_wdata[7:0];
			mgmt_pkg::REG_MDIO_WDATA_HI: rd_mux = mdio_wdata[15:8];
			mgmt_pkg::REG_MDIO_RDATA_LO: rd_mux = rdata_r[7:0];
			mgmt_pkg::REG_MDIO_RDATA_HI: rd_mux = rdata_r[15:8];
			default:                     rd_mux = '0;
		endcase
	end

	always_ff @(posedge sys_clk) begin
		if (rst)
			rd_valid <= 1'b0;
		else
			rd_valid <= rd_en;
	end

	always_ff @(posedge sys_clk) begin
		rd_data <= rd_mux;
	end

	//////////////////////////////////////////////////////////////////////
	// Checks

	// Read return is exactly one cycle behind the request
	a_rd_latency: assert property (@(posedge sys_clk) disable iff (rst)
		rd_valid |-> $past(rd_en));

	// Never restart the master mid transaction
	a_start_idle: assert property (@(posedge sys_clk) disable iff (rst)
		mdio_start |-> !mdio_busy);

endmodule

// File: hdl/mdio_pkg.sv
package mdio_pkg;

	//////////////////////////////////////////////////////////////////////
	// Timing and field widths

	// sys_clk cycles per MDC half period
	localparam int MDIO_CLK_DIV       = 10;
	localparam int MDIO_DIV_BITS      = $clog2(MDIO_CLK_DIV);
	localparam logic [MDIO_DIV_BITS-1:0] MDIO_DIV_LAST = MDIO_DIV_BITS'(MDIO_CLK_DIV - 1);

	localparam int MDIO_PREAMBLE_BITS = 32;
	localparam int MDIO_FRAME_BITS    = 32;
	localparam int PHY_ADDR_BITS      = 5;
	localparam int REG_ADDR_BITS      = 5;
	localparam int MDIO_DATA_BITS     = 16;

	// Bit positions, counted from the first preamble bit
	localparam int MDIO_TOTAL_BITS    = MDIO_PREAMBLE_BITS + MDIO_FRAME_BITS;
	localparam int MDIO_BIT_CNT_BITS  = $clog2(MDIO_TOTAL_BITS + 1);
	localparam logic [MDIO_BIT_CNT_BITS-1:0] MDIO_FRAME_FIRST =
		MDIO_BIT_CNT_BITS'(MDIO_PREAMBLE_BITS);
	localparam logic [MDIO_BIT_CNT_BITS-1:0] MDIO_TA_FIRST =
		MDIO_BIT_CNT_BITS'(MDIO_PREAMBLE_BITS + 4 + PHY_ADDR_BITS + REG_ADDR_BITS);
	localparam logic [MDIO_BIT_CNT_BITS-1:0] MDIO_DATA_FIRST =
		MDIO_BIT_CNT_BITS'(MDIO_TOTAL_BITS - MDIO_DATA_BITS);
	localparam logic [MDIO_BIT_CNT_BITS-1:0] MDIO_LAST_BIT =
		MDIO_BIT_CNT_BITS'(MDIO_TOTAL_BITS - 1);

	//////////////////////////////////////////////////////////////////////
	// Clause 22 codes

	localparam logic [1:0] MDIO_START    = 2'b01;
	localparam logic [1:0] OP_READ       = 2'b10;
	localparam logic [1:0] OP_WRITE      = 2'b01;
	localparam logic [1:0] MDIO_TA_WRITE = 2'b10;
	// Bus released for reads
	localparam logic [1:0] MDIO_TA_READ  = 2'b11;

	// Frame word, either shifted raw or built field by field
	typedef struct packed {
		logic [1:0]                start;
		logic [1:0]                op;
		logic [PHY_ADDR_BITS-1:0]  phy;
		logic [REG_ADDR_BITS-1:0]  reg_addr;
		logic [1:0]                ta;
		logic [MDIO_DATA_BITS-1:0] data;
	} mdio_fields_t;

	typedef union packed {
		logic [MDIO_FRAME_BITS-1:0] raw;
		mdio_fields_t               f;
	} mdio_frame_t;

endpackage

// File: hdl/mgmt_pkg.sv
package mgmt_pkg;

	//////////////////////////////////////////////////////////////////////
	// Register bus widths

	localparam int ADDR_BITS = 16;
	localparam int DATA_BITS = 8;

	//////////////////////////////////////////////////////////////////////
	// Register map

	// Fan speed, little endian byte pairs
	localparam logic [ADDR_BITS-1:0] REG_FAN0_RPM_LO   = 16'h0000;
	localparam logic [ADDR_BITS-1:0] REG_FAN0_RPM_HI   = 16'h0001;
	localparam logic [ADDR_BITS-1:0] REG_FAN1_RPM_LO   = 16'h0002;
	localparam logic [ADDR_BITS-1:0] REG_FAN1_RPM_HI   = 16'h0003;

	// MDIO master, bit 0 of status is busy
	localparam logic [ADDR_BITS-1:0] REG_MDIO_STATUS   = 16'h0010;
	localparam logic [ADDR_BITS-1:0] REG_MDIO_PHY_ADDR = 16'h0011;
	localparam logic [ADDR_BITS-1:0] REG_MDIO_REG_ADDR = 16'h0012;
	localparam logic [ADDR_BITS-1:0] REG_MDIO_WDATA_LO = 16'h0013;
	localparam logic [ADDR_BITS-1:0] REG_MDIO_WDATA_HI = 16'h0014;
	localparam logic [ADDR_BITS-1:0] REG_MDIO_CMD      = 16'h0015;
	localparam logic [ADDR_BITS-1:0] REG_MDIO_RDATA_LO = 16'h0016;
	localparam logic [ADDR_BITS-1:0] REG_MDIO_RDATA_HI = 16'h0017;

	// Command byte values
	localparam logic [DATA_BITS-1:0] CMD_READ  = 8'h01;
	localparam logic [DATA_BITS-1:0] CMD_WRITE = 8'h02;

	//////////////////////////////////////////////////////////////////////
	// Tachometers

	localparam int RPM_BITS           = 16;
	localparam int TACH_WINDOW_CYCLES = 1000;
	// Two pulses per revolution
	localparam int TACH_RPM_SCALE     = 30;

	// Wide enough for the window count and for the edges seen in one window
	localparam int TACH_WINDOW_BITS   = $clog2(TACH_WINDOW_CYCLES);
	localparam logic [TACH_WINDOW_BITS-1:0] TACH_WINDOW_LAST =
		TACH_WINDOW_BITS'(TACH_WINDOW_CYCLES - 1);

endpackage
